//--- Makefile
# Verilator flow for the image filter testbench.

TOP = image_filter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

# The run counts as passed only if the log holds the pass line.
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sim.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/dual_port_ram.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

// Line buffer with one registered read port and one write port.
module dual_port_ram #(
    parameter int item_count = `FRAME_WIDTH,
    parameter int data_width = `PIXEL_WIDTH
) (
    input logic clock_i,

    input logic read_enable_i,
    input filter_pkg::column_t read_address_i,
    output filter_pkg::pixel_t read_data_o,

    input logic write_enable_i,
    input filter_pkg::column_t write_address_i,
    input filter_pkg::pixel_t write_data_i
);

    logic [data_width-1:0] memory [item_count];

    always_ff @(posedge clock_i) begin
        if (write_enable_i) begin
            memory[write_address_i] <= data_width'(write_data_i);
        end
    end

    // The read data holds its value until the next enabled read.
    always_ff @(posedge clock_i) begin
        if (read_enable_i) begin
            read_data_o <= filter_pkg::pixel_t'(memory[read_address_i]);
        end
    end

endmodule : dual_port_ram

//--- logic/filter_consts.svh
`ifndef FILTER_CONSTS_SVH
`define FILTER_CONSTS_SVH

// Frame size of the raster stream.
// It is fixed when the design is built.
`define FRAME_HEIGHT 6
`define FRAME_WIDTH 8

// Edge of the square neighbourhood.
// The Gaussian kernel in the filter is only defined for an edge of 3.
`define WINDOW_SIZE 3

// Bits per pixel, both at the input and at the result.
`define PIXEL_WIDTH 8

`endif

//--- logic/filter_pkg.sv
`include "filter_consts.svh"

package filter_pkg;

    // One pixel of the raster stream.
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // A square neighbourhood of pixels.
    // Row 0 is the oldest row and column 0 is the leftmost pixel.
    typedef pixel_t [0:`WINDOW_SIZE-1][0:`WINDOW_SIZE-1] window_t;

    // Kernel sums before the final shift.
    // The largest value is 16 * 255, which needs 12 bits.
    typedef logic [11:0] weighted_sum_t;

    // Raster coordinates inside one frame.
    typedef logic [$clog2(`FRAME_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`FRAME_WIDTH)-1:0] column_t;

endpackage : filter_pkg

//--- logic/gaussian_filter.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

// Two-stage 3x3 Gaussian smoothing with the 1-2-1 / 2-4-2 / 1-2-1 kernel.
// The result is rounded and divided by 16.
module gaussian_filter (
    input logic clock_i,
    input logic reset_i,

    window_stream_if.sink window_i,

    output logic result_valid_o,
    input logic result_ready_i,
    output filter_pkg::pixel_t result_data_o,
    output logic result_last_o
);

    logic advance;
    filter_pkg::weighted_sum_t row_sum [`WINDOW_SIZE];

    logic stage_one_valid;
    logic stage_one_last;
    filter_pkg::weighted_sum_t stage_one_sum [`WINDOW_SIZE];

    filter_pkg::weighted_sum_t kernel_sum;

    // Both stages move together, so back-pressure freezes the whole pipeline.
    // A bubble in stage two lets it move even when the sink is not ready.
    assign advance = !result_valid_o || result_ready_i;
    assign window_i.ready = advance;

    // Horizontal pass, weights 1, 2 and 1 along each row.
    always_comb begin
        for (int r = 0; r < `WINDOW_SIZE; r++) begin
            row_sum[r] =
                filter_pkg::weighted_sum_t'(window_i.window[r][0]) +
                (filter_pkg::weighted_sum_t'(window_i.window[r][1]) << 1) +
                filter_pkg::weighted_sum_t'(window_i.window[r][2]);
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            stage_one_valid <= 1'b0;
            stage_one_last <= 1'b0;
        end else if (advance) begin
            stage_one_valid <= window_i.valid;
            stage_one_last <= window_i.valid && window_i.last;
        end
    end

    always_ff @(posedge clock_i) begin
        if (advance) begin
            for (int r = 0; r < `WINDOW_SIZE; r++) begin
                stage_one_sum[r] <= row_sum[r];
            end
        end
    end

    // Vertical pass, with 8 added for round-to-nearest before the divide.
    assign kernel_sum =
        stage_one_sum[0] +
        (stage_one_sum[1] << 1) +
        stage_one_sum[2] +
        filter_pkg::weighted_sum_t'(8);

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            result_valid_o <= 1'b0;
            result_last_o <= 1'b0;
        end else if (advance) begin
            result_valid_o <= stage_one_valid;
            result_last_o <= stage_one_last;
        end
    end

    always_ff @(posedge clock_i) begin
        if (advance) begin
            result_data_o <= filter_pkg::pixel_t'(kernel_sum >> 4);
        end
    end

endmodule : gaussian_filter

//--- logic/image_filter_top.sv
`timescale 1ns/10ps

// Streaming smoothing subsystem.
// Pixels come in raster order, smoothed pixels leave in raster order.
module image_filter_top (
    input logic clock_i,
    input logic reset_i,

    // Raster pixel input.
    input logic pixel_valid_i,
    output logic pixel_ready_o,
    input filter_pkg::pixel_t pixel_data_i,

    // Smoothed pixel output, one per window.
    output logic result_valid_o,
    input logic result_ready_i,
    output filter_pkg::pixel_t result_data_o,
    output logic result_last_o
);

    window_stream_if window_stream ();

    sliding_window window_unit (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .pixel_valid_i(pixel_valid_i),
        .pixel_ready_o(pixel_ready_o),
        .pixel_data_i(pixel_data_i),
        .window_o(window_stream.source)
    );

    gaussian_filter filter_unit (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .window_i(window_stream.sink),
        .result_valid_o(result_valid_o),
        .result_ready_i(result_ready_i),
        .result_data_o(result_data_o),
        .result_last_o(result_last_o)
    );

endmodule : image_filter_top

//--- logic/sliding_window.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

// Turns a raster pixel stream into a stream of square neighbourhoods.
// No padding is applied, so the first rows and columns of a frame give no window.
module sliding_window #(
    parameter int frame_height = `FRAME_HEIGHT,
    parameter int frame_width = `FRAME_WIDTH
) (
    input logic clock_i,
    input logic reset_i,

    input logic pixel_valid_i,
    output logic pixel_ready_o,
    input filter_pkg::pixel_t pixel_data_i,

    window_stream_if.source window_o
);

    // Previous rows live in line buffers, earlier columns in a shift register.
    localparam int ram_rows = `WINDOW_SIZE - 1;
    localparam int shift_columns = `WINDOW_SIZE - 1;

    logic accept;
    filter_pkg::row_t row;
    filter_pkg::row_t next_row;
    filter_pkg::column_t column;
    filter_pkg::column_t next_column;
    int ram_row;
    filter_pkg::pixel_t ram_read_data [ram_rows];
    filter_pkg::pixel_t right_column [`WINDOW_SIZE];
    filter_pkg::pixel_t shift_data [`WINDOW_SIZE][shift_columns];

    assign accept = pixel_valid_i && pixel_ready_o;

    // Raster position of the next pixel, wrapping at the end of the frame.
    always_comb begin
        if (column == filter_pkg::column_t'(frame_width - 1)) begin
            next_column = '0;
            if (row == filter_pkg::row_t'(frame_height - 1)) begin
                next_row = '0;
            end else begin
                next_row = row + 1'b1;
            end
        end else begin
            next_column = column + 1'b1;
            next_row = row;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            row <= '0;
            column <= '0;
        end else if (accept) begin
            row <= next_row;
            column <= next_column;
        end
    end

    // Frame row r is stored in line buffer r mod ram_rows.
    // That buffer therefore still holds the oldest row at the current column.
    assign ram_row = int'(row) % ram_rows;

    // Each buffer reads the next column ahead of time, so its data is ready
    // when the next pixel arrives.
    for (genvar i = 0; i < ram_rows; i++) begin : g_line_buffer
        dual_port_ram #(
            .item_count(frame_width),
            .data_width(`PIXEL_WIDTH)
        ) line_buffer (
            .clock_i(clock_i),
            .read_enable_i(accept),
            .read_address_i(next_column),
            .read_data_o(ram_read_data[i]),
            .write_enable_i(accept && ram_row == i),
            .write_address_i(column),
            .write_data_i(pixel_data_i)
        );
    end : g_line_buffer

    // The rightmost window column takes the buffered rows in age order,
    // then the live pixel at the bottom.
    always_comb begin
        for (int i = 0; i < ram_rows; i++) begin
            right_column[i] = ram_read_data[(ram_row + i) % ram_rows];
        end
        right_column[`WINDOW_SIZE-1] = pixel_data_i;
    end

    // Older columns move one step left on every accepted pixel.
    always_ff @(posedge clock_i) begin
        if (accept) begin
            for (int r = 0; r < `WINDOW_SIZE; r++) begin
                for (int c = 0; c < shift_columns - 1; c++) begin
                    shift_data[r][c] <= shift_data[r][c+1];
                end
                shift_data[r][shift_columns-1] <= right_column[r];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `WINDOW_SIZE; r++) begin
            for (int c = 0; c < shift_columns; c++) begin
                window_o.window[r][c] = shift_data[r][c];
            end
            window_o.window[r][`WINDOW_SIZE-1] = right_column[r];
        end
    end

    // A pixel is only taken when the filter can take the window it may complete.
    assign pixel_ready_o = reset_i && window_o.ready;

    assign window_o.valid =
        reset_i && pixel_valid_i &&
        row >= filter_pkg::row_t'(`WINDOW_SIZE - 1) &&
        column >= filter_pkg::column_t'(`WINDOW_SIZE - 1);

    // The window ending at the bottom-right pixel closes the frame.
    assign window_o.last =
        row == filter_pkg::row_t'(frame_height - 1) &&
        column == filter_pkg::column_t'(frame_width - 1);

endmodule : sliding_window

//--- logic/window_stream_if.sv
`timescale 1ns/10ps

// Carries one neighbourhood per transfer from the sliding window to the filter.
// A window moves on a clock edge where valid and ready are both high.
interface window_stream_if;

    logic valid;
    logic ready;
    filter_pkg::window_t window;

    // High on the final window of a frame.
    logic last;

    modport source (
        output valid,
        output window,
        output last,
        input ready
    );

    modport sink (
        input valid,
        input window,
        input last,
        output ready
    );

endinterface : window_stream_if

//--- sim.f
+incdir+logic
logic/filter_pkg.sv
logic/window_stream_if.sv
logic/dual_port_ram.sv
logic/sliding_window.sv
logic/gaussian_filter.sv
logic/image_filter_top.sv
testbench/image_filter_props.sv
testbench/image_filter_tb.sv

//--- testbench/image_filter_props.sv
`timescale 1ns/10ps

// Handshake and reset rules of the filter's outside ports.
module image_filter_props (
    input logic clock_i,
    input logic reset_i,
    input logic pixel_ready_i,
    input logic result_valid_i,
    input logic result_ready_i,
    input filter_pkg::pixel_t result_data_i,
    input logic result_last_i
);

    int failure_count = 0;

    // A result that waits for the sink keeps its value and its flag.
    result_held: assert property (
        @(posedge clock_i) disable iff (!reset_i)
        result_valid_i && !result_ready_i |=>
            result_valid_i && $stable(result_data_i) && $stable(result_last_i)
    ) else begin
        failure_count++;
        $error("Result changed while it waited for the sink");
    end

    // The pixel input takes nothing while reset is applied.
    pixel_idle_in_reset: assert property (
        @(posedge clock_i)
        !reset_i |-> !pixel_ready_i
    ) else begin
        failure_count++;
        $error("Pixel input was ready during reset");
    end

    // Reset empties the pipeline within one clock.
    result_idle_after_reset: assert property (
        @(posedge clock_i)
        !reset_i |=> !result_valid_i
    ) else begin
        failure_count++;
        $error("Result was still valid one cycle after reset");
    end

endmodule : image_filter_props

//--- testbench/image_filter_tb.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

module image_filter_tb;

    localparam int frame_pixels = `FRAME_HEIGHT * `FRAME_WIDTH;
    localparam int test_count = 7;

    typedef enum logic [1:0] {
        pattern_constant,
        pattern_ramp,
        pattern_random
    } pattern_t;

    // One row of the test table.
    typedef struct packed {
        pattern_t kind;
        filter_pkg::pixel_t fill;
        logic [6:0] stall_percent;
        logic [1:0] frame_count;
        logic reset_first;
        logic has_constant;
        filter_pkg::pixel_t constant_result;
    } test_row_t;

    logic clock_i = 1'b0;
    logic reset_i;
    logic pixel_valid_i;
    logic pixel_ready_o;
    filter_pkg::pixel_t pixel_data_i;
    logic result_valid_o;
    logic result_ready_i;
    filter_pkg::pixel_t result_data_o;
    logic result_last_o;

    test_row_t tests [test_count];
    string test_names [test_count];
    filter_pkg::pixel_t frame [`FRAME_HEIGHT][`FRAME_WIDTH];
    filter_pkg::pixel_t send_queue [$];
    filter_pkg::pixel_t expected_data [$];
    logic expected_last [$];
    int unsigned lcg_state = 32'd64093;
    int mismatch_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    always #2 clock_i = ~clock_i;

    image_filter_top UUT (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .pixel_valid_i(pixel_valid_i),
        .pixel_ready_o(pixel_ready_o),
        .pixel_data_i(pixel_data_i),
        .result_valid_o(result_valid_o),
        .result_ready_i(result_ready_i),
        .result_data_o(result_data_o),
        .result_last_o(result_last_o)
    );

    bind image_filter_top image_filter_props properties (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .pixel_ready_i(pixel_ready_o),
        .result_valid_i(result_valid_o),
        .result_ready_i(result_ready_i),
        .result_data_i(result_data_o),
        .result_last_i(result_last_o)
    );

    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped delivering results",
                cycle_count);
            $display("test failed");
            $finish;
        end
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic logic draw_stall(input int percent);
        return int'(next_random() % 32'd100) < percent;
    endfunction

    function automatic test_row_t table_row(input pattern_t kind, input int fill,
        input int stall_percent, input int frame_count, input int reset_first,
        input int constant_result);
        test_row_t row;
        row.kind = kind;
        row.fill = filter_pkg::pixel_t'(fill);
        row.stall_percent = 7'(stall_percent);
        row.frame_count = 2'(frame_count);
        row.reset_first = reset_first != 0;
        row.has_constant = constant_result >= 0;
        row.constant_result = filter_pkg::pixel_t'(constant_result);
        return row;
    endfunction

    // Reference smoothing of the window whose top-left pixel is (row, column).
    // Kernel weights are the outer product of 1-2-1 with itself, so they sum to 16.
    function automatic filter_pkg::pixel_t smooth_pixel(input int row, input int column);
        int weights [3] = '{1, 2, 1};
        int sum;
        sum = 0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                sum += weights[r] * weights[c] * int'(frame[row + r][column + c]);
            end
        end
        return filter_pkg::pixel_t'((sum + 8) / 16);
    endfunction

    task automatic load_tests();
        // A constant result of -1 means the reference model gives the expected values.
        tests[0] = table_row(pattern_constant, 8'hA5, 0, 1, 0, 8'hA5);
        tests[1] = table_row(pattern_constant, 8'hFF, 0, 1, 0, 8'hFF);
        tests[2] = table_row(pattern_ramp, 3, 0, 1, 0, -1);
        tests[3] = table_row(pattern_random, 0, 0, 1, 0, -1);
        tests[4] = table_row(pattern_random, 0, 40, 1, 0, -1);
        tests[5] = table_row(pattern_random, 0, 25, 2, 0, -1);
        tests[6] = table_row(pattern_ramp, 200, 10, 1, 1, -1);
        test_names = '{"constant_mid", "constant_white", "ramp", "random",
            "random_stalled", "two_frames", "reset_mid_frame"};
    endtask

    task automatic fill_frame(input test_row_t test);
        for (int r = 0; r < `FRAME_HEIGHT; r++) begin
            for (int c = 0; c < `FRAME_WIDTH; c++) begin
                case (test.kind)
                    pattern_constant: frame[r][c] = test.fill;
                    pattern_ramp: frame[r][c] =
                        filter_pkg::pixel_t'(int'(test.fill) + 16 * r + 2 * c);
                    default: frame[r][c] = filter_pkg::pixel_t'(next_random());
                endcase
            end
        end
    endtask

    // Builds the pixel stream of a test and its results in raster order.
    task automatic prepare_test(input int index);
        test_row_t test;
        test = tests[index];
        send_queue.delete();
        expected_data.delete();
        expected_last.delete();
        for (int f = 0; f < int'(test.frame_count); f++) begin
            fill_frame(test);
            for (int r = 0; r < `FRAME_HEIGHT; r++) begin
                for (int c = 0; c < `FRAME_WIDTH; c++) begin
                    send_queue.push_back(frame[r][c]);
                end
            end
            for (int r = 0; r < `FRAME_HEIGHT - 2; r++) begin
                for (int c = 0; c < `FRAME_WIDTH - 2; c++) begin
                    expected_data.push_back(test.has_constant ? test.constant_result
                        : smooth_pixel(r, c));
                    expected_last.push_back(r == `FRAME_HEIGHT - 3 && c == `FRAME_WIDTH - 3);
                end
            end
        end
    endtask

    task automatic check_result(input int index, input int position);
        assert (result_data_o == expected_data[position]) else begin
            mismatch_count++;
            $display("MISMATCH %s result %0d: expected %0d, actual %0d", test_names[index],
                position, expected_data[position], result_data_o);
        end
        assert (result_last_o == expected_last[position]) else begin
            mismatch_count++;
            $display("MISMATCH %s last flag of result %0d: expected %0d, actual %0d",
                test_names[index], position, expected_last[position], result_last_o);
        end
    endtask

    // Half a frame of throwaway pixels, then reset in the middle of the frame.
    task automatic interrupt_with_reset(input int index);
        repeat (frame_pixels / 2) begin
            @(posedge clock_i);
            #1;
            pixel_valid_i = 1'b1;
            pixel_data_i = filter_pkg::pixel_t'(next_random());
            result_ready_i = 1'b1;
        end
        @(posedge clock_i);
        #1;
        reset_i = 1'b0;
        for (int k = 0; k < 2; k++) begin
            #2;
            assert (!pixel_ready_o) else begin
                error_count++;
                $display("Test %s saw the pixel input ready during reset", test_names[index]);
            end
            if (k > 0) begin
                assert (!result_valid_o) else begin
                    error_count++;
                    $display("Test %s saw a valid result during reset", test_names[index]);
                end
            end
            @(posedge clock_i);
            #1;
        end
        reset_i = 1'b1;
        pixel_valid_i = 1'b0;
    endtask

    // Offers pixels and takes results with random gaps, checking each result as it goes.
    task automatic stream_frames(input int index);
        int pixel_index;
        int result_index;
        int stall_percent;
        logic offered;
        pixel_index = 0;
        result_index = 0;
        stall_percent = int'(tests[index].stall_percent);
        offered = 1'b0;
        while (result_index < expected_data.size()) begin
            @(posedge clock_i);
            #1;
            // An offered pixel stays on the bus until it is taken.
            if (!offered) begin
                if (pixel_index < send_queue.size() && !draw_stall(stall_percent)) begin
                    pixel_valid_i = 1'b1;
                    pixel_data_i = send_queue[pixel_index];
                    offered = 1'b1;
                end else begin
                    pixel_valid_i = 1'b0;
                end
            end
            result_ready_i = !draw_stall(stall_percent);
            #2;
            if (pixel_valid_i && pixel_ready_o) begin
                pixel_index++;
                offered = 1'b0;
            end
            if (result_valid_o && result_ready_i) begin
                check_result(index, result_index);
                result_index++;
            end
        end
        // Any result after the last expected one would be a duplicate.
        repeat (4) begin
            @(posedge clock_i);
            #1;
            pixel_valid_i = 1'b0;
            result_ready_i = 1'b1;
            #2;
            assert (!result_valid_o) else begin
                error_count++;
                $display("Test %s gave a result after its last expected one", test_names[index]);
            end
        end
    endtask

    initial begin
        int total_frames;
        reset_i = 1'b0;
        pixel_valid_i = 1'b0;
        pixel_data_i = '0;
        result_ready_i = 1'b0;
        load_tests();
        // Four cycles per pixel is ample even with the heaviest stall rate.
        total_frames = 0;
        for (int t = 0; t < test_count; t++) begin
            total_frames += int'(tests[t].frame_count) + int'(tests[t].reset_first);
        end
        cycle_limit = 4 * total_frames * frame_pixels + 100;
        repeat (2) @(posedge clock_i);
        #1;
        reset_i = 1'b1;
        for (int t = 0; t < test_count; t++) begin
            prepare_test(t);
            if (tests[t].reset_first) begin
                interrupt_with_reset(t);
            end
            stream_frames(t);
        end
        error_count += UUT.properties.failure_count;
        $display("Mismatches: %0d, other errors: %0d", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : image_filter_tb
